// ==== bitslip_ctrl.sv ====
`timescale 1ns/1ps

`include "emmc_link_defs.svh"

module bitslip_ctrl (
   input  logic                       txclk_div,
   input  logic                       rst,
   input  emmc_link_pkg::lane_word_t  algn_clk_word, // Clock lane from the aligner
   output logic                       bitslip,       // One cycle slip strobe
   output logic                       aligned        // Training word locked
);

   emmc_link_pkg::bitslip_state_t state;      // Current hunt state
   emmc_link_pkg::bitslip_state_t state_nxt;  // Next hunt state
   logic [emmc_link_pkg::SLIP_WAIT_CNT_W-1:0] wait_cnt; // Cycles spent in BS_WAIT
   logic                                      ptrn_ok;  // Clock word is the training word

   assign ptrn_ok = (algn_clk_word == `TRAIN_PATTERN);

   // State register
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         state <= emmc_link_pkg::BS_CHECK;
      end else begin
         state <= state_nxt;
      end
   end

   // Wait counter, restarts on every entry into BS_WAIT
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         wait_cnt <= '0;
      end else if (state == emmc_link_pkg::BS_WAIT) begin
         wait_cnt <= wait_cnt + 1'b1;
      end else begin
         wait_cnt <= '0;
      end
   end

   // Hunt sequence is CHECK, SLIP, WAIT, WAIT so one attempt takes 4 cycles
   always_comb begin
      state_nxt = state;
      case (state)
         emmc_link_pkg::BS_CHECK: begin
            if (ptrn_ok) begin
               state_nxt = emmc_link_pkg::BS_LOCKED;
            end else begin
               state_nxt = emmc_link_pkg::BS_SLIP;
            end
         end
         emmc_link_pkg::BS_SLIP: begin
            state_nxt = emmc_link_pkg::BS_WAIT; // Strobe lasts one cycle only
         end
         emmc_link_pkg::BS_WAIT: begin
            // Aligner output carries the new offset by the last wait cycle
            if (wait_cnt == emmc_link_pkg::SLIP_WAIT_LAST) begin
               state_nxt = emmc_link_pkg::BS_CHECK;
            end
         end
         emmc_link_pkg::BS_LOCKED: begin
            // Lost the pattern, slip at once instead of judging again
            if (!ptrn_ok) begin
               state_nxt = emmc_link_pkg::BS_SLIP;
            end
         end
         default: begin
            state_nxt = emmc_link_pkg::BS_CHECK;
         end
      endcase
   end

   assign bitslip = (state == emmc_link_pkg::BS_SLIP);

   // Falls in the very cycle the clock word goes wrong
   assign aligned = (state == emmc_link_pkg::BS_LOCKED) && ptrn_ok;

   // Worst case is 8 attempts of 4 cycles before the offset wraps back
   // A wrong training word on the wire never locks and keeps slipping

endmodule

// ==== emmc_link_defs.svh ====
`ifndef EMMC_LINK_DEFS_SVH
`define EMMC_LINK_DEFS_SVH

// Parallel word width on both serializer lanes
`define LANE_W 8

// Slip offset covers every bit position of one lane word
`define SLIP_W 3

// Clock lane training word, 11000011 as sent by the remote end
`define TRAIN_PATTERN 8'hC3

// Idle cycles after a bitslip strobe before the clock word is judged again
// The aligner needs 2 cycles until the new offset shows at its output
`define SLIP_WAIT 2

// SD data bus width carried in the data lane word
`define SD_DAT_W 4

// Data lane bit positions
`define DAT_BIT_CMD   0 // cmd_o on transmit, cmd_i on receive
`define DAT_BIT_CMD_T 1 // Command output enable
`define DAT_BIT_DAT_T 2 // Data output enable
`define DAT_BIT_DAT   3 // Lowest bit of sd_dat_o on transmit

`endif

// ==== emmc_link_pkg.sv ====
`include "emmc_link_defs.svh"

package emmc_link_pkg;

   // One parallel word on a lane, bit 0 is the first bit on the wire
   typedef logic [`LANE_W-1:0] lane_word_t;

   // Bitslip hunt states
   typedef enum logic [1:0] {
      BS_CHECK  = 2'd0, // Judge the aligned clock word
      BS_SLIP   = 2'd1, // One cycle bitslip strobe
      BS_WAIT   = 2'd2, // Let the new offset reach the aligner output
      BS_LOCKED = 2'd3  // Training word seen, lanes usable
   } bitslip_state_t;

   // Width of the wait counter in BS_WAIT
   localparam int unsigned SLIP_WAIT_CNT_W = 2;

   // Value of the wait counter on the last wait cycle
   localparam logic [SLIP_WAIT_CNT_W-1:0] SLIP_WAIT_LAST =
      SLIP_WAIT_CNT_W'(`SLIP_WAIT - 1);

endpackage

// ==== emmc_link_top.sv ====
`timescale 1ns/1ps

`include "emmc_link_defs.svh"

module emmc_link_top (
   input  logic                       txclk_div,   // Divided lane clock
   input  logic                       rst,         // Synchronous, active low

   // Host side transmit signals
   input  logic                       cmd_o,
   input  logic                       cmd_t,
   input  logic                       sd_dat_t,
   input  logic [`SD_DAT_W-1:0]       sd_dat_o,

   // Unaligned words from the deserializers
   input  emmc_link_pkg::lane_word_t  rx_clk_word,
   input  emmc_link_pkg::lane_word_t  rx_dat_word,

   // Words towards the serializers
   output emmc_link_pkg::lane_word_t  tx_clk_word,
   output emmc_link_pkg::lane_word_t  tx_dat_word,

   // Host side receive signals
   output logic                       cmd_i,
   output logic [`SD_DAT_W-1:0]       sd_dat_i,
   output logic                       aligned      // cmd_i and sd_dat_i valid
);

   emmc_link_pkg::lane_word_t algn_clk_word; // Clock lane after the barrel shift
   emmc_link_pkg::lane_word_t algn_dat_word; // Data lane, same shift as clock lane
   logic                      bitslip;       // One cycle slip request

   // Transmit side, one cycle from host pins to lane word
   tx_lane_packer u_tx_lane_packer (
      .txclk_div   (txclk_div),
      .rst         (rst),
      .cmd_o       (cmd_o),
      .cmd_t       (cmd_t),
      .sd_dat_t    (sd_dat_t),
      .sd_dat_o    (sd_dat_o),
      .tx_clk_word (tx_clk_word),
      .tx_dat_word (tx_dat_word)
   );

   // Receive side barrel shifter, both lanes share one offset
   rx_word_aligner u_rx_word_aligner (
      .txclk_div     (txclk_div),
      .rst           (rst),
      .rx_clk_word   (rx_clk_word),
      .rx_dat_word   (rx_dat_word),
      .bitslip       (bitslip),
      .algn_clk_word (algn_clk_word),
      .algn_dat_word (algn_dat_word)
   );

   // Hunts for the training word on the aligned clock lane
   bitslip_ctrl u_bitslip_ctrl (
      .txclk_div     (txclk_div),
      .rst           (rst),
      .algn_clk_word (algn_clk_word),
      .bitslip       (bitslip),
      .aligned       (aligned)
   );

   // Unpack the receive word
   // Remote end packs the command in bit 0 and the data nibble right above it
   assign cmd_i    = algn_dat_word[`DAT_BIT_CMD];
   assign sd_dat_i = algn_dat_word[`SD_DAT_W:1]; // Bits 4..1

   // Bits 7..5 of the receive word carry no host signal

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the emmc link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_emmc_link

sim_out="$(./obj_dir/Vtb_emmc_link)"
echo "$sim_out"

# Pass only when the testbench printed its pass line
if echo "$sim_out" | grep -qx "Testbench passed"; then
   exit 0
fi
exit 1

// ==== rx_word_aligner.sv ====
`timescale 1ns/1ps

`include "emmc_link_defs.svh"

module rx_word_aligner (
   input  logic                       txclk_div,
   input  logic                       rst,
   input  emmc_link_pkg::lane_word_t  rx_clk_word,   // Raw clock lane word
   input  emmc_link_pkg::lane_word_t  rx_dat_word,   // Raw data lane word
   input  logic                       bitslip,       // Single cycle strobe
   output emmc_link_pkg::lane_word_t  algn_clk_word, // Shifted clock lane word
   output emmc_link_pkg::lane_word_t  algn_dat_word  // Shifted data lane word
);

   emmc_link_pkg::lane_word_t prev_clk_word; // Raw clock word of the last cycle
   emmc_link_pkg::lane_word_t prev_dat_word; // Raw data word of the last cycle
   logic [`SLIP_W-1:0]        slip_ofs;      // Shared bit offset into the window
   emmc_link_pkg::lane_word_t clk_shift;     // Window slice, clock lane
   emmc_link_pkg::lane_word_t dat_shift;     // Window slice, data lane

   // Picks LANE_W bits starting at ofs out of the two word window
   // The current word sits above the previous one, older bits are lower
   function automatic emmc_link_pkg::lane_word_t slice_window(
      input emmc_link_pkg::lane_word_t cur,
      input emmc_link_pkg::lane_word_t prev,
      input logic [`SLIP_W-1:0]        ofs
   );
      logic [2*`LANE_W-1:0] win;
      win          = {cur, prev};
      slice_window = win[ofs +: `LANE_W];
   endfunction

   // One word of history per lane
   always_ff @(posedge txclk_div) begin
      prev_clk_word <= rx_clk_word;
      prev_dat_word <= rx_dat_word;
   end

   // Each strobe moves the window up by one bit, wraps after LANE_W slips
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         slip_ofs <= '0;
      end else if (bitslip) begin
         slip_ofs <= slip_ofs + 1'b1; // Modulo 8 by width
      end
   end

   // Same offset on both lanes keeps data locked to the clock lane
   always_comb begin
      clk_shift = slice_window(rx_clk_word, prev_clk_word, slip_ofs);
      dat_shift = slice_window(rx_dat_word, prev_dat_word, slip_ofs);
   end

   // Output register, so a new offset shows 2 cycles after its strobe
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         algn_clk_word <= '0;
         algn_dat_word <= '0;
      end else begin
         algn_clk_word <= clk_shift;
         algn_dat_word <= dat_shift;
      end
   end

   // At offset 0 the output is just the previous raw word
   // At offset 7 it takes 1 bit from the previous word and 7 from the current one
   // A slip attempt never loses a word, the lanes keep flowing every cycle

endmodule

// ==== tb_emmc_link.sv ====
`timescale 1ns/1ps

`include "emmc_link_defs.svh"

module tb_emmc_link;

   localparam int CLK_PERIOD  = 20;
   localparam int DRIVE_DLY   = 2;   // Inputs change this long after the rising edge
   localparam int RST_CYC     = 8;
   localparam int PHASES      = 6;   // First delay after reset plus five delay changes
   localparam int PHASE_CYC   = 200; // Cycle budget of one phase
   localparam int PHASE_RUN   = 140; // Locked cycles per phase
   localparam int FRAME_LEN   = 4;   // Cycles a data frame is held
   localparam int LOCK_LIMIT  = 40;  // 8 attempts of 4 cycles plus margin
   localparam int DROP_LIMIT  = 4;
   localparam int WATCHDOG_NS = (RST_CYC + PHASES * PHASE_CYC) * CLK_PERIOD;
   localparam logic [31:0] LFSR_SEED = 32'h9c89_0d98;
   localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;

   // DUT ports
   logic                      txclk_div = 1'b0;
   logic                      rst;
   logic                      cmd_o;
   logic                      cmd_t;
   logic                      sd_dat_t;
   logic [`SD_DAT_W-1:0]      sd_dat_o;
   emmc_link_pkg::lane_word_t rx_clk_word;
   emmc_link_pkg::lane_word_t rx_dat_word;
   emmc_link_pkg::lane_word_t tx_clk_word;
   emmc_link_pkg::lane_word_t tx_dat_word;
   logic                      cmd_i;
   logic [`SD_DAT_W-1:0]      sd_dat_i;
   logic                      aligned;

   // Remote end stream model
   logic [31:0]               lfsr_state = LFSR_SEED;
   logic [2:0]                bit_dly    = 3'd0; // Wire delay k in bits
   int                        word_idx   = 0;    // Index of the next word to send
   emmc_link_pkg::lane_word_t clk_prev   = '0;   // Undelayed words of the last cycle
   emmc_link_pkg::lane_word_t dat_prev   = '0;
   logic                      frm_cmd    = 1'b0; // Fields of the current frame
   logic [`SD_DAT_W-1:0]      frm_dat    = '0;

   // Frame fields two words back as the DUT shows them once locked
   logic                      cmd_d1     = 1'b0;
   logic                      cmd_d2     = 1'b0;
   logic [`SD_DAT_W-1:0]      dat_d1     = '0;
   logic [`SD_DAT_W-1:0]      dat_d2     = '0;
   logic                      mid_d1     = 1'b0;
   logic                      mid_d2     = 1'b0;
   logic                      exp_cmd    = 1'b0;
   logic [`SD_DAT_W-1:0]      exp_dat    = '0;
   logic                      exp_mid    = 1'b0; // Middle two cycles of a frame

   // Lock tracking
   logic                      hunting    = 1'b0;
   logic                      dropping   = 1'b0;
   int                        hunt_cyc   = 0;
   int                        drop_cyc   = 0;

   // Transmit side expectation taken at each rising edge
   logic                      clk_seen    = 1'b0;
   logic                      rst_at_edge = 1'b0;
   emmc_link_pkg::lane_word_t exp_tx_dat  = '0;

   int                        mismatch_cnt = 0;
   int                        fail_cnt     = 0;

   emmc_link_top dut0 (
      .txclk_div   (txclk_div),
      .rst         (rst),
      .cmd_o       (cmd_o),
      .cmd_t       (cmd_t),
      .sd_dat_t    (sd_dat_t),
      .sd_dat_o    (sd_dat_o),
      .rx_clk_word (rx_clk_word),
      .rx_dat_word (rx_dat_word),
      .tx_clk_word (tx_clk_word),
      .tx_dat_word (tx_dat_word),
      .cmd_i       (cmd_i),
      .sd_dat_i    (sd_dat_i),
      .aligned     (aligned)
   );

   always #(CLK_PERIOD / 2) txclk_div = ~txclk_div;

   // Galois LFSR stepped once per bit
   function automatic logic lfsr_next_bit();
      logic out;
      out        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) begin
         lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      return out;
   endfunction

   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      int         i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v[i] = lfsr_next_bit();
      end
      return v;
   endfunction

   // Data lane layout towards the wire
   function automatic emmc_link_pkg::lane_word_t tx_word_of(
      input logic                 c,
      input logic                 ct,
      input logic                 dt,
      input logic [`SD_DAT_W-1:0] d
   );
      return {1'b0, d, dt, ct, c}; // Bit 7 spare with data in 6..3
   endfunction

   // Word seen at the receiver when the bit stream arrives k bits late
   function automatic emmc_link_pkg::lane_word_t delay_word(
      input emmc_link_pkg::lane_word_t cur,
      input emmc_link_pkg::lane_word_t prev,
      input logic [2:0]                k
   );
      logic [2*`LANE_W-1:0] win;
      win = {cur, prev} >> (`LANE_W - int'(k)); // Older bits sit low
      return win[`LANE_W-1:0];
   endfunction

   task automatic report_mismatch(input string sig, input logic [7:0] exp, input logic [7:0] act);
      mismatch_cnt++;
      $display("mismatch time=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
   endtask

   task automatic report_failure(input string msg);
      fail_cnt++;
      $display("error at %0t: %s", $time, msg);
   endtask

   always @(posedge txclk_div) begin
      clk_seen    <= 1'b1;
      rst_at_edge <= rst;
      exp_tx_dat  <= tx_word_of(cmd_o, cmd_t, sd_dat_t, sd_dat_o); // Shows after this edge
   end

   // Checks sample on the falling edge when all outputs are settled
   a_rst_clk: assert property (@(negedge txclk_div)
      (clk_seen && !rst_at_edge) |-> (tx_clk_word == '0))
      else report_mismatch("tx_clk_word", 8'h00, tx_clk_word);
   a_rst_dat: assert property (@(negedge txclk_div)
      (clk_seen && !rst_at_edge) |-> (tx_dat_word == '0))
      else report_mismatch("tx_dat_word", 8'h00, tx_dat_word);
   a_rst_algn: assert property (@(negedge txclk_div)
      (clk_seen && !rst_at_edge) |-> (aligned == 1'b0))
      else report_mismatch("aligned", 8'h00, {7'b0, aligned});
   a_tx_dat: assert property (@(negedge txclk_div)
      (clk_seen && rst_at_edge) |-> (tx_dat_word == exp_tx_dat))
      else report_mismatch("tx_dat_word", exp_tx_dat, tx_dat_word);
   a_tx_clk: assert property (@(negedge txclk_div)
      (clk_seen && rst_at_edge) |-> (tx_clk_word == `TRAIN_PATTERN))
      else report_mismatch("tx_clk_word", `TRAIN_PATTERN, tx_clk_word);
   a_rx_cmd: assert property (@(negedge txclk_div)
      (aligned && exp_mid) |-> (cmd_i == exp_cmd))
      else report_mismatch("cmd_i", {7'b0, exp_cmd}, {7'b0, cmd_i});
   a_rx_dat: assert property (@(negedge txclk_div)
      (aligned && exp_mid) |-> (sd_dat_i == exp_dat))
      else report_mismatch("sd_dat_i", {4'b0, exp_dat}, {4'b0, sd_dat_i});
   a_lock: assert property (@(negedge txclk_div) hunt_cyc <= LOCK_LIMIT)
      else report_failure($sformatf("aligned did not rise within %0d cycles, bit delay %0d",
                                    LOCK_LIMIT, bit_dly));
   a_drop: assert property (@(negedge txclk_div) drop_cyc <= DROP_LIMIT)
      else report_failure($sformatf("aligned stayed high after the bit delay changed to %0d",
                                    bit_dly));

   // Next word pair from the remote end with the same delay on both lanes
   // The stream runs from time zero so the lanes carry the training word in reset
   task automatic drive_remote_words();
      int                        pos;
      logic [7:0]                r;
      emmc_link_pkg::lane_word_t dat_now;
      logic                      mid_now;
      pos = word_idx % FRAME_LEN;
      if (pos == 0) begin
         r       = rand_bits(5); // New frame
         frm_cmd = r[0];
         frm_dat = r[4:1];
      end
      dat_now     = {3'b000, frm_dat, frm_cmd}; // Card side layout
      mid_now     = (pos == 1 || pos == 2);
      rx_clk_word = delay_word(`TRAIN_PATTERN, clk_prev, bit_dly);
      rx_dat_word = delay_word(dat_now, dat_prev, bit_dly);
      clk_prev    = `TRAIN_PATTERN;
      dat_prev    = dat_now;
      exp_cmd     = cmd_d2; // Output since the last edge holds word n-2
      exp_dat     = dat_d2;
      exp_mid     = mid_d2;
      cmd_d2      = cmd_d1;
      dat_d2      = dat_d1;
      mid_d2      = mid_d1;
      cmd_d1      = frm_cmd;
      dat_d1      = frm_dat;
      mid_d1      = mid_now;
      word_idx++;
   endtask

   task automatic track_lock();
      if (!hunting) begin
         hunt_cyc = 0;
      end else if (!aligned) begin
         hunt_cyc++;
      end
      if (!dropping) begin
         drop_cyc = 0;
      end else if (aligned) begin
         drop_cyc++;
      end
   endtask

   // One clock cycle of stimulus
   task automatic step_cycle();
      logic [7:0] r;
      @(posedge txclk_div);
      #DRIVE_DLY;
      r        = rand_bits(7);
      cmd_o    = r[0];
      cmd_t    = r[1];
      sd_dat_t = r[2];
      sd_dat_o = r[6:3];
      drive_remote_words();
      track_lock();
   endtask

   // New delay at a frame boundary followed by drop, relock and a locked run
   task automatic run_phase(input int phase_no);
      logic [7:0] r;
      logic [2:0] new_k;
      r     = rand_bits(3);
      new_k = r[2:0];
      if (phase_no > 0 && new_k == bit_dly) begin
         new_k = new_k + 3'd1; // Must differ or lock is never lost
      end
      while (word_idx % FRAME_LEN != 0) begin
         step_cycle();
      end
      bit_dly   = new_k;
      hunting   = 1'b1;
      dropping  = (phase_no > 0);
      while (dropping && aligned && drop_cyc <= DROP_LIMIT) begin
         step_cycle();
      end
      dropping = 1'b0;
      while (!aligned && hunt_cyc <= LOCK_LIMIT) begin
         step_cycle();
      end
      hunting = 1'b0;
      repeat (PHASE_RUN) begin
         step_cycle();
      end
   endtask

   initial begin
      int phase_no;
      rst         = 1'b0;
      cmd_o       = 1'b0;
      cmd_t       = 1'b0;
      sd_dat_t    = 1'b0;
      sd_dat_o    = '0;
      rx_clk_word = '0;
      rx_dat_word = '0;
      repeat (RST_CYC) begin
         step_cycle();
      end
      rst = 1'b1;
      for (phase_no = 0; phase_no < PHASES; phase_no++) begin
         run_phase(phase_no);
      end
      $display("errors: mismatches %0d, other failures %0d", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      report_failure("watchdog expired, the run did not finish");
      $display("errors: mismatches %0d, other failures %0d", mismatch_cnt, fail_cnt);
      $display("Testbench failed");
      $finish;
   end

endmodule

// ==== tx_lane_packer.sv ====
`timescale 1ns/1ps

`include "emmc_link_defs.svh"

module tx_lane_packer (
   input  logic                       txclk_div,
   input  logic                       rst,
   input  logic                       cmd_o,       // Command bit
   input  logic                       cmd_t,       // Command output enable
   input  logic                       sd_dat_t,    // Data output enable
   input  logic [`SD_DAT_W-1:0]       sd_dat_o,    // Data nibble
   output emmc_link_pkg::lane_word_t  tx_clk_word, // Training word for the clock lane
   output emmc_link_pkg::lane_word_t  tx_dat_word  // Packed data word
);

   emmc_link_pkg::lane_word_t dat_pack; // Combinational packing of the host pins

   // Bit order 0 cmd_o, 1 cmd_t, 2 sd_dat_t, 6..3 sd_dat_o, 7 spare
   always_comb begin
      dat_pack                                       = '0;
      dat_pack[`DAT_BIT_CMD]                         = cmd_o;
      dat_pack[`DAT_BIT_CMD_T]                       = cmd_t;
      dat_pack[`DAT_BIT_DAT_T]                       = sd_dat_t;
      dat_pack[`DAT_BIT_DAT +: `SD_DAT_W]            = sd_dat_o;
   end

   // Data word register, 1 cycle latency from the host pins
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         tx_dat_word <= '0;
      end else begin
         tx_dat_word <= dat_pack;
      end
   end

   // Clock lane runs the training word as soon as reset is gone
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         tx_clk_word <= '0; // Quiet lane while in reset
      end else begin
         tx_clk_word <= `TRAIN_PATTERN;
      end
   end

endmodule

// ==== verilog.f ====
+incdir+.
emmc_link_pkg.sv
tx_lane_packer.sv
rx_word_aligner.sv
bitslip_ctrl.sv
emmc_link_top.sv
tb_emmc_link.sv
